// File: common/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // frame format is fixed at 8N1
    localparam int DATA_BITS    = 8;                // payload bits per frame
    localparam int OVERSAMPLE   = 16;               // os ticks per bit period
    localparam int FRAME_SHIFTS = DATA_BITS + 2;    // start + data + stop
    localparam int TX_REG_W     = DATA_BITS + 3;    // plus the idle continuation bit

    // timing strobes from the baud generator
    // both are single-cycle pulses
    typedef struct packed {
        logic os_tick;     // 16x oversample tick
        logic bit_tick;    // every OVERSAMPLE-th os tick
    } baud_ticks_t;

    // received byte as presented at the top level
    typedef struct packed {
        logic [DATA_BITS-1:0] data;         // LSB-aligned byte
        logic                 frame_err;    // stop bit was sampled low
    } rx_frame_t;

    // per-bit commands from the receive FSM to the data register
    typedef struct packed {
        logic sample;     // one-cycle strobe at mid data bit
        logic bit_val;    // synchronized line value at the sample point
        logic done;       // one-cycle strobe at mid stop bit
        logic stop_ok;    // stop bit value, 1 is a good frame
    } rx_step_t;

endpackage

`default_nettype wire

// File: src/baud_gen.sv
`default_nettype none

module baud_gen #(
    parameter int CLK_DIV = 4    // clk cycles per os tick
) (
    input  wire                   clk,
    input  wire                   rst,
    output uart_pkg::baud_ticks_t ticks
);
    import uart_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int OS_W  = $clog2(OVERSAMPLE);

    logic [DIV_W-1:0] div_cnt;     // position inside one os period
    logic [OS_W-1:0]  os_cnt;      // os ticks seen in the current bit
    logic             div_wrap;    // last clk of the os period
    logic             os_wrap;     // last os tick of the bit

    if (CLK_DIV < 2) begin : g_div_check
        $error("baud_gen needs CLK_DIV of at least 2");
    end

    assign div_wrap = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign os_wrap  = (os_cnt == OS_W'(OVERSAMPLE - 1));

    // clock divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (div_wrap) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // oversample counter, steps once per os period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            os_cnt <= '0;
        end else if (div_wrap) begin
            os_cnt <= os_wrap ? '0 : os_cnt + 1'b1;
        end
    end

    // ticks leave from flops so downstream sees clean pulses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ticks <= '0;
        end else begin
            ticks.os_tick  <= div_wrap;
            ticks.bit_tick <= div_wrap && os_wrap;
        end
    end

    // a bit tick is always also an os tick
    a_bit_on_os: assert property (@(posedge clk) disable iff (rst)
        ticks.bit_tick |-> ticks.os_tick);

    // os ticks come exactly CLK_DIV cycles apart
    a_os_period: assert property (@(posedge clk) disable iff (rst)
        ticks.os_tick |=> !ticks.os_tick [*(CLK_DIV - 1)] ##1 ticks.os_tick);

endmodule

`default_nettype wire

// File: tx/tx_ctrl.sv
`default_nettype none

module tx_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  wire uart_pkg::baud_ticks_t  ticks,
    input  wire                         load,           // request to send
    output logic                        load_accept,    // parallel load of the tx register
    output logic                        shift,          // one shift of the tx register
    output logic                        idle            // transmit status
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(FRAME_SHIFTS + 1);

    typedef enum logic {
        ST_IDLE,
        ST_SHIFT
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;          // shifts left in this frame
    logic             last_shift;   // stop bit is moving onto txd

    assign idle        = (state == ST_IDLE);
    assign load_accept = load && idle;                      // busy loads are dropped here
    assign shift       = ticks.bit_tick && (state == ST_SHIFT);
    assign last_shift  = shift && (cnt == CNT_W'(1));

    // frame FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load_accept) begin
                        state <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    if (last_shift) begin
                        state <= ST_IDLE;     // idle again with stop bit on the line
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // shift counter, held at full count while idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= CNT_W'(FRAME_SHIFTS);
        end else if (idle) begin
            cnt <= CNT_W'(FRAME_SHIFTS);
        end else if (shift) begin
            cnt <= cnt - 1'b1;
        end
    end

    // a load is only taken from idle and always starts a frame
    a_load_from_idle: assert property (@(posedge clk) disable iff (rst)
        load_accept |-> idle ##1 !idle);

    // counter never runs out while a frame is in flight
    a_cnt_live: assert property (@(posedge clk) disable iff (rst)
        !idle |-> cnt != '0);

endmodule

`default_nettype wire

// File: tx/tx_shift_reg.sv
`default_nettype none

module tx_shift_reg (
    input  wire                           clk,
    input  wire                           rst,
    input  wire [uart_pkg::DATA_BITS-1:0] data,           // byte to serialize
    input  wire                           load_accept,    // parallel load strobe
    input  wire                           shift,          // shift one bit toward txd
    output logic                          txd             // serial line
);
    import uart_pkg::*;

    // layout after a load
    //   [10]   stop bit
    //   [9:2]  data, LSB at bit 2
    //   [1]    start bit
    //   [0]    continuation bit, keeps the line high
    logic [TX_REG_W-1:0] t_reg;

    assign txd = t_reg[0];    // bit 0 drives the line

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            t_reg <= '1;                                    // line idles high
        end else if (load_accept) begin
            t_reg <= {1'b1, data, 1'b0, 1'b1};
        end else if (shift) begin
            t_reg <= {1'b1, t_reg[TX_REG_W-1:1]};           // ones fill from the top
        end
    end

    // FSM never loads and shifts in the same cycle
    a_load_shift_excl: assert property (@(posedge clk) disable iff (rst)
        !(load_accept && shift));

    // line stays high from a load until the first shift
    a_hold_after_load: assert property (@(posedge clk) disable iff (rst)
        load_accept |=> txd);

endmodule

`default_nettype wire

// File: rx/rx_ctrl.sv
`default_nettype none

module rx_ctrl (
    input  wire                        clk,
    input  wire                        rst,
    input  wire uart_pkg::baud_ticks_t ticks,
    input  wire                        rxd,     // raw serial line
    output uart_pkg::rx_step_t         step     // strobes to the rx data register
);
    import uart_pkg::*;

    localparam int PH_W  = $clog2(OVERSAMPLE);
    localparam int BIT_W = $clog2(DATA_BITS);

    typedef enum logic [1:0] {
        ST_IDLE,     // waiting for a low line
        ST_START,    // half bit into a possible start bit
        ST_DATA,     // sampling data bits
        ST_STOP      // waiting for the stop bit centre
    } state_t;

    state_t           state;
    logic             rxd_meta;     // first sync stage
    logic             rxd_sync;     // second sync stage, safe to use
    logic [PH_W-1:0]  phase;        // os ticks since the last sample point
    logic [BIT_W-1:0] bit_cnt;      // data bits taken so far
    logic             mid_start;    // centre of the start bit
    logic             mid_bit;      // centre of a data or stop bit

    // two-flop synchronizer, resets to idle line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign mid_start = ticks.os_tick && (phase == PH_W'(OVERSAMPLE / 2 - 1));
    assign mid_bit   = ticks.os_tick && (phase == PH_W'(OVERSAMPLE - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            phase   <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    phase   <= '0;
                    bit_cnt <= '0;
                    if (ticks.os_tick && !rxd_sync) begin
                        state <= ST_START;      // falling edge seen
                    end
                end
                ST_START: begin
                    if (mid_start) begin
                        phase <= '0;
                        // line high again means a glitch, drop it
                        state <= rxd_sync ? ST_IDLE : ST_DATA;
                    end else if (ticks.os_tick) begin
                        phase <= phase + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (mid_bit) begin
                        phase   <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                            state <= ST_STOP;   // last data bit taken
                        end
                    end else if (ticks.os_tick) begin
                        phase <= phase + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (mid_bit) begin
                        phase <= '0;
                        state <= ST_IDLE;       // ready for the next start edge
                    end else if (ticks.os_tick) begin
                        phase <= phase + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // strobes to the data register
    always_comb begin
        step.sample  = mid_bit && (state == ST_DATA);
        step.bit_val = rxd_sync;
        step.done    = mid_bit && (state == ST_STOP);
        step.stop_ok = rxd_sync;
    end

    // a data sample and the stop check never share a cycle
    a_sample_done_excl: assert property (@(posedge clk) disable iff (rst)
        !(step.sample && step.done));

endmodule

`default_nettype wire

// File: rx/rx_shift_reg.sv
`default_nettype none

module rx_shift_reg (
    input  wire                     clk,
    input  wire                     rst,
    input  wire uart_pkg::rx_step_t step,        // strobes from the rx FSM
    output uart_pkg::rx_frame_t     rx_frame,    // held until the next frame
    output logic                    rx_valid     // one cycle after the stop sample
);
    import uart_pkg::*;

    logic [DATA_BITS-1:0] shift_q;    // byte being assembled

    // LSB arrives first, so bits enter at the top and walk down
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q <= '0;
        end else if (step.sample) begin
            shift_q <= {step.bit_val, shift_q[DATA_BITS-1:1]};
        end
    end

    // publish the byte at the stop sample
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_frame <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= step.done;                  // single-cycle pulse
            if (step.done) begin
                rx_frame.data      <= shift_q;
                rx_frame.frame_err <= !step.stop_ok;    // low stop bit
            end
        end
    end

    // output frame only changes together with a valid pulse
    a_frame_stable: assert property (@(posedge clk) disable iff (rst)
        !$stable(rx_frame) |-> rx_valid);

    // valid never lasts more than a cycle
    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: src/mini_uart.sv
`default_nettype none

module mini_uart #(
    parameter int CLK_DIV = 4    // clk cycles per os tick, at least 2
) (
    input  wire                           clk,
    input  wire                           rst,
    // transmit side
    input  wire [uart_pkg::DATA_BITS-1:0] tx_data,     // byte to send
    input  wire                           tx_load,     // taken only while tx_idle
    output logic                          tx_idle,     // transmitter free
    output logic                          txd,         // serial out, idles high
    // receive side
    input  wire                           rxd,         // serial in, async to clk
    output uart_pkg::rx_frame_t           rx_frame,    // last received byte
    output logic                          rx_valid     // one pulse per frame
);
    import uart_pkg::*;

    baud_ticks_t ticks;          // shared timing strobes
    logic        load_accept;    // load taken by the tx FSM
    logic        shift;          // one tx register shift
    rx_step_t    step;           // rx FSM to rx data register

    // one divider feeds both directions
    baud_gen #(
        .CLK_DIV (CLK_DIV)
    ) u_baud_gen (
        .clk   (clk),
        .rst   (rst),
        .ticks (ticks)
    );

    // transmit unit
    tx_ctrl u_tx_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ticks       (ticks),
        .load        (tx_load),
        .load_accept (load_accept),
        .shift       (shift),
        .idle        (tx_idle)
    );

    tx_shift_reg u_tx_shift_reg (
        .clk         (clk),
        .rst         (rst),
        .data        (tx_data),
        .load_accept (load_accept),
        .shift       (shift),
        .txd         (txd)
    );

    // receive unit
    rx_ctrl u_rx_ctrl (
        .clk   (clk),
        .rst   (rst),
        .ticks (ticks),
        .rxd   (rxd),
        .step  (step)
    );

    rx_shift_reg u_rx_shift_reg (
        .clk      (clk),
        .rst      (rst),
        .step     (step),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid)
    );

endmodule

`default_nettype wire

// File: verification/tb_mini_uart.sv
`default_nettype none

module tb_mini_uart;
    timeunit 1ns;
    timeprecision 1ps;
    import uart_pkg::*;

    localparam int CLK_DIV      = 4;
    localparam int BIT_CYC      = OVERSAMPLE * CLK_DIV;    // 64 clk per bit
    localparam int FRAME_CYC    = 10 * BIT_CYC;            // start + 8 data + stop
    localparam int WATCHDOG_CYC = 40 * FRAME_CYC + 2000;   // longest run plus margin

    logic       clk;
    logic       rst;
    logic [7:0] tx_data;
    logic       tx_load;
    logic       tx_idle;
    logic       txd;
    wire        rxd;
    rx_frame_t  rx_frame;
    logic       rx_valid;

    logic       loop_en;        // 1 routes txd back into rxd
    logic       rxd_drv;        // direct line drive
    int         valid_cnt;      // rx_valid pulses seen
    logic [7:0] got_data;       // last published byte
    logic       got_err;
    int         errors;
    int         tests_pass;
    int         tests_fail;
    integer     seed;

    assign rxd = loop_en ? txd : rxd_drv;    // loopback mux

    mini_uart #(
        .CLK_DIV (CLK_DIV)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_load  (tx_load),
        .tx_idle  (tx_idle),
        .txd      (txd),
        .rxd      (rxd),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period
    end

    // rx monitor, counts pulses and keeps the last frame
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_cnt <= 0;
        end else if (rx_valid) begin
            valid_cnt <= valid_cnt + 1;
            got_data  <= rx_frame.data;
            got_err   <= rx_frame.frame_err;
        end
    end

    initial begin
        #(WATCHDOG_CYC * 10);
        $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYC);
        $display("Done: errors found");
        $finish;
    end

    task automatic report_mismatch(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_fault(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_pass++;
            $display("PASS %s", name);
        end else begin
            tests_fail++;
            $display("FAIL %s (%0d errors)", name, errors - err_before);
        end
    endtask

    // waits for tx_idle, then a one-cycle load strobe
    task automatic load_byte(input logic [7:0] b);
        int k;
        k = 0;
        while (tx_idle !== 1'b1 && k < 2 * FRAME_CYC) begin
            @(posedge clk);
            k++;
        end
        if (tx_idle !== 1'b1) report_fault("transmitter never returned to idle");
        tx_data <= b;
        tx_load <= 1'b1;
        @(posedge clk);
        tx_load <= 1'b0;
    endtask

    task automatic wait_valid(input int n0, input int limit, output bit got);
        int k;
        got = 1'b0;
        k = 0;
        while (!got && k < limit) begin
            @(posedge clk);
            k++;
            if (valid_cnt != n0) got = 1'b1;
        end
    endtask

    // full frame driven straight onto rxd, LSB first
    task automatic drive_frame(input logic [7:0] b, input logic stop);
        logic [9:0] bits;
        int         i;
        bits = {stop, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            rxd_drv <= bits[i];
            repeat (BIT_CYC) @(posedge clk);
        end
        rxd_drv <= 1'b1;
    endtask

    // receive one frame and check it, then check for a lone pulse
    task automatic expect_frame(input int n0, input logic [7:0] b, input logic err);
        bit got;
        wait_valid(n0, 2 * FRAME_CYC, got);
        if (!got) begin
            report_fault($sformatf("rx_valid never came for byte %02h", b));
        end else begin
            if (got_data !== b)
                report_mismatch($sformatf("rx data %02h, expected %02h", got_data, b));
            if (got_err !== err)
                report_mismatch($sformatf("frame_err %0b, expected %0b", got_err, err));
        end
        repeat (BIT_CYC) @(posedge clk);
        if (valid_cnt - n0 != 1)
            report_mismatch($sformatf("%0d rx_valid pulses for one frame", valid_cnt - n0));
    endtask

    task automatic test_reset_state();
        int e0;
        int k;
        e0 = errors;
        if (txd !== 1'b1) report_mismatch("txd not high after reset");
        if (tx_idle !== 1'b1) report_mismatch("tx_idle not high after reset");
        for (k = 0; k < 4 * BIT_CYC; k++) begin
            if (rx_valid !== 1'b0) report_mismatch("rx_valid on an idle line");
            @(posedge clk);
        end
        finish_test("reset state", e0);
    endtask

    task automatic test_tx_waveform();
        logic [7:0] b;
        logic [9:0] exp_bits;    // index 0 is the start bit
        int         e0;
        int         n0;
        int         k;
        int         i;
        bit         got;
        e0 = errors;
        b = 8'h4b;
        exp_bits = {1'b1, b, 1'b0};
        n0 = valid_cnt;
        load_byte(b);
        k = 0;
        while (txd !== 1'b0 && k < 2 * BIT_CYC) begin
            @(posedge clk);
            k++;
        end
        if (txd !== 1'b0) begin
            report_fault("no start edge on txd after a load");
        end else begin
            repeat (BIT_CYC / 2) @(posedge clk);    // to mid bit
            for (i = 0; i < 10; i++) begin
                if (txd !== exp_bits[i])
                    report_mismatch($sformatf("txd bit %0d is %0b", i, txd));
                if (i == 0 && tx_idle !== 1'b0) report_mismatch("tx_idle high in start bit");
                if (i == 9 && tx_idle !== 1'b1) report_mismatch("tx_idle low in stop bit");
                if (i < 9) repeat (BIT_CYC) @(posedge clk);
            end
        end
        wait_valid(n0, FRAME_CYC, got);
        if (!got) report_fault("looped back frame never raised rx_valid");
        finish_test("tx waveform", e0);
    endtask

    task automatic test_loopback();
        logic [31:0] rnd;
        logic [7:0]  b;
        int          e0;
        int          n0;
        int          i;
        e0 = errors;
        for (i = 0; i < 21; i++) begin
            rnd = $random(seed);
            b = (i == 0) ? 8'ha5 : rnd[7:0];    // one fixed byte, then random
            n0 = valid_cnt;
            load_byte(b);
            expect_frame(n0, b, 1'b0);
        end
        finish_test("loopback", e0);
    endtask

    task automatic test_busy_load();
        int e0;
        int n0;
        int k;
        e0 = errors;
        n0 = valid_cnt;
        load_byte(8'h3c);
        k = 0;
        while (tx_idle !== 1'b0 && k < 8) begin
            @(posedge clk);
            k++;
        end
        tx_data <= 8'hc3;    // second load while busy
        tx_load <= 1'b1;
        @(posedge clk);
        tx_load <= 1'b0;
        expect_frame(n0, 8'h3c, 1'b0);
        repeat (2 * FRAME_CYC) @(posedge clk);
        if (valid_cnt - n0 != 1) report_mismatch("busy load produced a second frame");
        finish_test("busy load ignored", e0);
    endtask

    task automatic test_frame_error();
        int e0;
        int n0;
        e0 = errors;
        loop_en <= 1'b0;
        @(posedge clk);
        n0 = valid_cnt;
        drive_frame(8'h96, 1'b0);
        expect_frame(n0, 8'h96, 1'b1);
        finish_test("framing error", e0);
    endtask

    task automatic test_false_start();
        int e0;
        int n0;
        e0 = errors;
        n0 = valid_cnt;
        rxd_drv <= 1'b0;
        repeat (3 * CLK_DIV) @(posedge clk);    // 3 os ticks low
        rxd_drv <= 1'b1;
        repeat (FRAME_CYC + BIT_CYC) @(posedge clk);    // a frame begun by the glitch ends by now
        if (valid_cnt != n0) report_mismatch("glitch raised rx_valid");
        drive_frame(8'h5e, 1'b1);
        expect_frame(n0, 8'h5e, 1'b0);
        loop_en <= 1'b1;
        finish_test("false start", e0);
    endtask

    initial begin
        rst = 1'b1;
        tx_data = 8'h00;
        tx_load = 1'b0;
        rxd_drv = 1'b1;
        loop_en = 1'b1;
        errors = 0;
        tests_pass = 0;
        tests_fail = 0;
        seed = 32'h762c;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_state();
        test_tx_waveform();
        test_loopback();
        test_busy_load();
        test_frame_error();
        test_false_start();
        $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
common/uart_pkg.sv
src/baud_gen.sv
tx/tx_ctrl.sv
tx/tx_shift_reg.sv
rx/rx_ctrl.sv
rx/rx_shift_reg.sv
src/mini_uart.sv
verification/tb_mini_uart.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_mini_uart
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
